//--- hdl/star_settings.svh
/*
 * Star-field layer settings
 * Counter widths, line and frame extents, pixel enable divider
 * and APB register offsets.
 */
`ifndef STAR_SETTINGS_SVH
`define STAR_SETTINGS_SVH

`define STAR_DUMP_W       9       // hdump and vdump width
`define STAR_CEN_W        2       // pixel enable divider counter width
`define STAR_CEN_DIV      4       // clocks per pixel

`define STAR_HDUMP_MAX    9'd511  // last pixel of a line
`define STAR_VDUMP_MAX    9'd261  // last line of a frame
`define STAR_HS_START     9'd432
`define STAR_HS_END       9'd464
`define STAR_VB_START     9'd240  // blank wraps through line 0
`define STAR_VB_END       9'd16

`define STAR_CACHE_DEPTH  16      // star bytes per line
`define STAR_ROM_AW       13
`define STAR_APB_AW       8

`define STAR_REG_HPOS0    8'h00
`define STAR_REG_VPOS0    8'h04
`define STAR_REG_HPOS1    8'h08
`define STAR_REG_VPOS1    8'h0C
`define STAR_REG_CTRL     8'h10

`endif

//--- hdl/star_pkg.sv
/*
 * Star-field shared types
 * Packed structs for video timing, field config, ROM requests,
 * pixels and APB, plus the arbiter owner encoding.
 */
`default_nettype none

`include "star_settings.svh"

package star_pkg;

    localparam logic [3:0] CLR_TRANSP = 4'hF; // transparent colour code

    // timing word sent to every field
    typedef struct packed {
        logic                    pxl_cen;
        logic                    hs;
        logic                    vb;
        logic [`STAR_DUMP_W-1:0] hdump;
        logic [`STAR_DUMP_W-1:0] vdump;
    } video_t;

    typedef struct packed {
        logic [`STAR_DUMP_W-1:0] hpos;
        logic [`STAR_DUMP_W-1:0] vpos;
        logic                    flip;
    } field_cfg_t;

    typedef struct packed {
        logic                    cs;
        logic [`STAR_ROM_AW-1:0] addr;  // {cache index, effective line}
    } rom_req_t;

    typedef struct packed {
        logic [2:0] pal;
        logic [3:0] color;  // 0xF is see-through
    } star_pxl_t;

    typedef struct packed {
        logic      field;   // 1 when field 1 supplied the pixel
        star_pxl_t pxl;
    } out_pxl_t;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`STAR_APB_AW-1:0] paddr;
        logic [31:0]             pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic {
        OWN_F0 = 1'b0,
        OWN_F1 = 1'b1
    } owner_e;

endpackage

`default_nettype wire

//--- hdl/star_video_timing.sv
/*
 * Star-field video timing
 * Divides clk down to the pixel enable and runs the hdump and
 * vdump counters. HS and VB are decoded into registers.
 */
`timescale 1ns/10ps
`default_nettype none

`include "star_settings.svh"

module star_video_timing (
    input  wire              clk,
    input  wire              rst,
    output star_pkg::video_t video
);

    logic [`STAR_CEN_W-1:0]  cen_cnt;
    logic                    pxl_cen;
    logic [`STAR_DUMP_W-1:0] hdump;
    logic [`STAR_DUMP_W-1:0] vdump;
    logic                    hs;
    logic                    vb;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
            hdump   <= '0;
            vdump   <= '0;
            hs      <= 1'b0;
            vb      <= 1'b0;
        end else begin
            // one enable every STAR_CEN_DIV clocks
            cen_cnt <= (cen_cnt == `STAR_CEN_W'(`STAR_CEN_DIV - 1)) ? '0 : cen_cnt + 1'd1;
            pxl_cen <= cen_cnt == `STAR_CEN_W'(`STAR_CEN_DIV - 1);
            if (pxl_cen) begin
                if (hdump == `STAR_HDUMP_MAX) begin
                    hdump <= '0;
                    vdump <= (vdump == `STAR_VDUMP_MAX) ? '0 : vdump + 1'd1; // frame wrap
                end else begin
                    hdump <= hdump + 1'd1;
                end
                // sync and blank lag the counters by one pixel
                hs <= hdump >= `STAR_HS_START && hdump < `STAR_HS_END;
                vb <= vdump >= `STAR_VB_START || vdump < `STAR_VB_END; // wraps past 0
            end
        end
    end

    assign video = '{
        pxl_cen: pxl_cen,
        hs:      hs,
        vb:      vb,
        hdump:   hdump,
        vdump:   vdump
    };

endmodule

`default_nettype wire

//--- hdl/star_regs.sv
/*
 * Star-field control registers
 * APB slave with scroll positions for both fields and a control
 * word (flip, en0, en1). No wait states.
 */
`timescale 1ns/10ps
`default_nettype none

`include "star_settings.svh"

module star_regs (
    input  wire                   clk,
    input  wire                   rst,
    input  star_pkg::apb_req_t    apb_req,
    output star_pkg::apb_rsp_t    apb_rsp,
    output star_pkg::field_cfg_t  cfg0,
    output star_pkg::field_cfg_t  cfg1,
    output logic [1:0]            en
);

    logic                    access;
    logic                    mapped;
    logic [31:0]             rdata;
    logic [`STAR_DUMP_W-1:0] hpos0, vpos0, hpos1, vpos1;
    logic [2:0]              ctrl;  // {en1, en0, flip}

    assign access = apb_req.psel & apb_req.penable; // access phase

    // address decode and read mux
    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (apb_req.paddr)
            `STAR_REG_HPOS0: rdata = {23'd0, hpos0};
            `STAR_REG_VPOS0: rdata = {23'd0, vpos0};
            `STAR_REG_HPOS1: rdata = {23'd0, hpos1};
            `STAR_REG_VPOS1: rdata = {23'd0, vpos1};
            `STAR_REG_CTRL:  rdata = {29'd0, ctrl};
            default:         mapped = 1'b0;  // rdata stays zero
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hpos0 <= '0;
            vpos0 <= '0;
            hpos1 <= '0;
            vpos1 <= '0;
            ctrl  <= '0;
        end else if (access && apb_req.pwrite && mapped) begin
            case (apb_req.paddr)
                `STAR_REG_HPOS0: hpos0 <= apb_req.pwdata[8:0];
                `STAR_REG_VPOS0: vpos0 <= apb_req.pwdata[8:0];
                `STAR_REG_HPOS1: hpos1 <= apb_req.pwdata[8:0];
                `STAR_REG_VPOS1: vpos1 <= apb_req.pwdata[8:0];
                default:         ctrl  <= apb_req.pwdata[2:0]; // only CTRL left
            endcase
        end
    end

    assign apb_rsp = '{
        prdata:  access ? rdata : 32'd0,
        pready:  access,
        pslverr: access & ~mapped
    };

    // flip is common to both fields
    assign cfg0 = '{hpos: hpos0, vpos: vpos0, flip: ctrl[0]};
    assign cfg1 = '{hpos: hpos1, vpos: vpos1, flip: ctrl[0]};
    assign en   = ctrl[2:1];

endmodule

`default_nettype wire

//--- hdl/star_field.sv
/*
 * Star-field generator
 * Refills a 16-byte line cache from the star ROM after each HS,
 * then turns the byte of each 32-pixel cell into one star pixel.
 * Star colours twinkle with two frame-driven counters.
 */
`timescale 1ns/10ps
`default_nettype none

`include "star_settings.svh"

module star_field #(
    parameter int FIELD = 0
) (
    input  wire                   clk,
    input  wire                   rst,
    input  star_pkg::video_t      video,
    input  star_pkg::field_cfg_t  cfg,
    output star_pkg::rom_req_t    rom_req,
    input  wire [31:0]            rom_data,
    input  wire                   rom_ok,
    output star_pkg::star_pxl_t   pxl
);

    localparam int         CW        = $clog2(`STAR_CACHE_DEPTH);
    localparam logic [3:0] FCNT_INIT = (FIELD != 0) ? 4'h8 : 4'h0; // half-period apart

    logic [7:0]              cache [`STAR_CACHE_DEPTH];
    logic [CW-1:0]           cache_cnt;
    logic                    fill, hs_l, vb_l;
    logic [`STAR_DUMP_W-1:0] veff;
    logic [3:0]              fcnt, cnt15, cnt16;
    logic [3:0]              hpos_n, idx_sum, rom_hpos;
    logic [7:0]              star_data;
    logic [4:0]              xs_cnt, pos;
    logic [2:0]              pal_id;
    logic                    blank;

    // cache index as the ROM sees it
    assign hpos_n   = ~cfg.hpos[8:5];
    assign idx_sum  = hpos_n + cache_cnt + 4'd2;
    assign rom_hpos = ~(idx_sum ^ {4{cfg.flip}});
    assign rom_req  = '{cs: fill, addr: {rom_hpos, veff}};

    // fill burst control
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hs_l      <= 1'b0;
            fill      <= 1'b0;
            cache_cnt <= '0;
        end else if (video.pxl_cen) begin
            hs_l <= video.hs;
            if (!video.hs && hs_l) begin    // HS falling edge
                fill      <= 1'b1;
                cache_cnt <= '0;
            end else if (fill && rom_ok) begin
                if (cache_cnt == CW'(`STAR_CACHE_DEPTH - 1))
                    fill <= 1'b0;           // last byte in
                else
                    cache_cnt <= cache_cnt + 1'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (video.pxl_cen && fill && rom_ok)
            cache[cache_cnt] <= rom_data[7:0]; // only low byte carries stars
    end

    // effective line and twinkle counters
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            veff  <= '0;
            vb_l  <= 1'b0;
            fcnt  <= FCNT_INIT;
            cnt15 <= '0;
            cnt16 <= '0;
        end else if (video.pxl_cen) begin
            if (!fill)                      // line held through the burst
                veff <= (cfg.vpos + video.vdump) ^ {`STAR_DUMP_W{cfg.flip}};
            vb_l <= video.vb;
            if (video.vb && !vb_l) begin    // once per frame
                fcnt <= fcnt + 1'd1;
                if (&fcnt) begin            // every 16 frames
                    cnt15 <= (cnt15 == 4'd14) ? 4'd0 : cnt15 + 1'd1; // never 0xF
                    cnt16 <= cnt16 + 1'd1;
                end
            end
        end
    end

    // stage 1: cache byte for the current cell
    always_ff @(posedge clk) begin
        if (video.pxl_cen)
            star_data <= cache[video.hdump[8:5]];
    end

    // stage 2: star position and colour
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            xs_cnt <= '0;
            pos    <= '0;
            pal_id <= '0;
            blank  <= 1'b1;
            pxl    <= '{pal: 3'd0, color: star_pkg::CLR_TRANSP};
        end else if (video.pxl_cen) begin
            if (video.hdump[4:0] == 5'd0)
                xs_cnt <= ~cfg.hpos[4:0];   // fine scroll inside the cell
            else
                xs_cnt <= xs_cnt - 1'd1;
            if (xs_cnt == 5'd0) begin
                pal_id <= star_data[7:5];
                pos    <= star_data[4:0] ^ {5{cfg.flip}};
                blank  <= star_data[4:0] == 5'hF;
            end else begin
                pos <= pos - 1'd1;
            end
            pxl.pal   <= pal_id;
            pxl.color <= (pos == 5'd0 && !blank) ? (pal_id[2] ? cnt15 : cnt16)
                                                 : star_pkg::CLR_TRANSP;
        end
    end

endmodule

`default_nettype wire

//--- hdl/star_rom_arbiter.sv
/*
 * Burst ROM arbiter
 * Two clients share one ROM port. A client keeps the port until
 * it drops cs. Client 0 wins a tie.
 */
`timescale 1ns/10ps
`default_nettype none

module star_rom_arbiter #(
    parameter type req_t = star_pkg::rom_req_t
) (
    input  wire  clk,
    input  wire  rst,
    input  req_t req0,
    input  req_t req1,
    output logic ok0,
    output logic ok1,
    output req_t rom_req,
    input  wire  rom_ok
);

    star_pkg::owner_e owner;
    logic             busy;
    logic             owner_cs;

    assign owner_cs = (owner == star_pkg::OWN_F1) ? req1.cs : req0.cs;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= star_pkg::OWN_F0;
        end else if (!busy) begin
            if (req0.cs) begin          // field 0 first
                busy  <= 1'b1;
                owner <= star_pkg::OWN_F0;
            end else if (req1.cs) begin
                busy  <= 1'b1;
                owner <= star_pkg::OWN_F1;
            end
        end else if (!owner_cs) begin
            busy <= 1'b0;               // burst over, rearbitrate next clock
        end
    end

    // port idles with cs low
    always_comb begin
        rom_req = '0;
        if (busy)
            rom_req = (owner == star_pkg::OWN_F1) ? req1 : req0;
    end

    assign ok0 = rom_ok & busy & (owner == star_pkg::OWN_F0);
    assign ok1 = rom_ok & busy & (owner == star_pkg::OWN_F1);

endmodule

`default_nettype wire

//--- hdl/star_mixer.sv
/*
 * Star-field mixer
 * Registered merge of both fields. Field 0 has priority and
 * disabled or see-through pixels fall through.
 */
`timescale 1ns/10ps
`default_nettype none

module star_mixer (
    input  wire                  clk,
    input  wire                  rst,
    input  star_pkg::star_pxl_t  pxl0,
    input  star_pkg::star_pxl_t  pxl1,
    input  wire [1:0]            en,
    output star_pkg::out_pxl_t   pixel_out
);

    localparam star_pkg::out_pxl_t NO_STAR = '{
        field: 1'b0,
        pxl:   '{pal: 3'd0, color: star_pkg::CLR_TRANSP}
    };

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            pixel_out <= NO_STAR;
        else if (en[0] && pxl0.color != star_pkg::CLR_TRANSP)
            pixel_out <= '{field: 1'b0, pxl: pxl0};
        else if (en[1] && pxl1.color != star_pkg::CLR_TRANSP)
            pixel_out <= '{field: 1'b1, pxl: pxl1}; // field bit marks layer 1
        else
            pixel_out <= NO_STAR;
    end

endmodule

`default_nettype wire

//--- hdl/star_top.sv
/*
 * Star-field layer top
 * Video timing, APB registers, two star fields sharing one ROM
 * port through the arbiter, and the output mixer.
 */
`timescale 1ns/10ps
`default_nettype none

module star_top (
    input  wire                 clk,
    input  wire                 rst,
    input  star_pkg::apb_req_t  apb_req,
    output star_pkg::apb_rsp_t  apb_rsp,
    output star_pkg::rom_req_t  rom_req,
    input  wire [31:0]          rom_data,
    input  wire                 rom_ok,
    output star_pkg::video_t    video,
    output star_pkg::out_pxl_t  pixel_out
);

    star_pkg::field_cfg_t cfg0, cfg1;
    star_pkg::rom_req_t   req0, req1;
    star_pkg::star_pxl_t  pxl0, pxl1;
    logic                 ok0, ok1;
    logic [1:0]           en;

    star_video_timing u_timing (
        .clk   (clk),
        .rst   (rst),
        .video (video)
    );

    star_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cfg0    (cfg0),
        .cfg1    (cfg1),
        .en      (en)
    );

    // both fields read the same ROM data bus
    star_field #(.FIELD(0)) u_field0 (
        .clk      (clk),
        .rst      (rst),
        .video    (video),
        .cfg      (cfg0),
        .rom_req  (req0),
        .rom_data (rom_data),
        .rom_ok   (ok0),
        .pxl      (pxl0)
    );

    star_field #(.FIELD(1)) u_field1 (
        .clk      (clk),
        .rst      (rst),
        .video    (video),
        .cfg      (cfg1),
        .rom_req  (req1),
        .rom_data (rom_data),
        .rom_ok   (ok1),
        .pxl      (pxl1)
    );

    star_rom_arbiter #(.req_t(star_pkg::rom_req_t)) u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .req0    (req0),
        .req1    (req1),
        .ok0     (ok0),
        .ok1     (ok1),
        .rom_req (rom_req),
        .rom_ok  (rom_ok)
    );

    star_mixer u_mixer (
        .clk       (clk),
        .rst       (rst),
        .pxl0      (pxl0),
        .pxl1      (pxl1),
        .en        (en),
        .pixel_out (pixel_out)
    );

endmodule

`default_nettype wire

//--- sim/star_assertions.sv
/*
 * Star-field layer checker
 * Concurrent assertions bound into the layer top: APB ready,
 * reset state, ROM request stability and mixer enables.
 */
`timescale 1ns/10ps
`default_nettype none

module star_assertions (
    input wire                 clk,
    input wire                 rst,
    input star_pkg::apb_req_t  apb_req,
    input star_pkg::apb_rsp_t  apb_rsp,
    input star_pkg::rom_req_t  rom_req,
    input wire                 rom_ok,
    input star_pkg::out_pxl_t  pixel_out,
    input wire [1:0]           en
);

    localparam star_pkg::out_pxl_t NO_STAR = '{
        field: 1'b0,
        pxl:   '{pal: 3'd0, color: star_pkg::CLR_TRANSP}
    };

    int fail_cnt = 0;   // failure tally

    // no wait states
    apb_ready: assert property (@(posedge clk) disable iff (rst)
        apb_req.psel && apb_req.penable |-> apb_rsp.pready)
    else begin
        $error("pready low in an APB access phase");
        fail_cnt++;
    end

    // quiet outputs while reset holds
    reset_idle: assert property (@(posedge clk)
        rst |-> !rom_req.cs && pixel_out == NO_STAR)
    else begin
        $error("rom_req.cs or pixel_out active during reset");
        fail_cnt++;
    end

    reset_exit: assert property (@(posedge clk)
        $fell(rst) |-> !rom_req.cs && pixel_out == NO_STAR)
    else begin
        $error("rom_req.cs or pixel_out active in the first cycle after reset");
        fail_cnt++;
    end

    // request held until taken
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        rom_req.cs && !rom_ok |=> $stable(rom_req.addr))
    else begin
        $error("ROM address moved while a request waited");
        fail_cnt++;
    end

    // mixer output lags en by one clock
    only_field1: assert property (@(posedge clk) disable iff (rst)
        $past(en) == 2'b10 && pixel_out.pxl.color != star_pkg::CLR_TRANSP
            |-> pixel_out.field)
    else begin
        $error("field 0 pixel passed with only field 1 enabled");
        fail_cnt++;
    end

    all_off: assert property (@(posedge clk) disable iff (rst)
        $past(en) == 2'b00 |-> pixel_out == NO_STAR)
    else begin
        $error("pixel_out not transparent with both fields disabled");
        fail_cnt++;
    end

endmodule

`default_nettype wire

//--- sim/star_tb.sv
/*
 * Star-field layer testbench
 * Drives APB and a ROM model with random latency into the layer top,
 * counts fill words and checks ROM line addresses. The bound checker
 * covers reset state, APB ready, request stability and the mixer.
 */
`timescale 1ns/10ps
`default_nettype none

`include "star_settings.svh"

module star_tb;

    localparam logic [31:0] SEED       = 32'hdffe_e55e;
    localparam int          LINE_CLKS  = (`STAR_HDUMP_MAX + 1) * `STAR_CEN_DIV;
    localparam int          HS_TIMEOUT = 2 * LINE_CLKS;   // two whole lines
    localparam int          APB_TIMEOUT = 16;

    logic                clk = 1'b0;
    logic                rst;
    star_pkg::apb_req_t  apb_req;
    star_pkg::apb_rsp_t  apb_rsp;
    star_pkg::rom_req_t  rom_req;
    logic [31:0]         rom_data;
    logic                rom_ok;
    star_pkg::video_t    video;
    star_pkg::out_pxl_t  pixel_out;

    logic [31:0] rnd_state = SEED;
    logic        rom_armed = 1'b0;
    logic [1:0]  rom_wait;
    logic [8:0]  fill_vdump;         // vdump when the fill burst started
    logic [8:0]  exp_vpos0, exp_vpos1;
    logic        exp_flip;
    bit          check_addr;
    int          line_words, star_cnt;
    int          check_errs, addr_errs, err_mark, asrt_mark;
    int          tests_run, tests_failed;

    always #20 clk = ~clk;           // 40 ns period

    star_top uut (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .rom_req   (rom_req),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .video     (video),
        .pixel_out (pixel_out)
    );

    bind star_top star_assertions u_assert (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .rom_req   (rom_req),
        .rom_ok    (rom_ok),
        .pixel_out (pixel_out),
        .en        (en)              // internal enable pair of the top
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // star byte as a hash of the whole address
    function automatic logic [7:0] star_byte(input logic [12:0] addr);
        logic [31:0] h;
        h = lcg_next(SEED ^ {19'd0, addr});
        return h[23:16];
    endfunction

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // effective line of an accepted word, field 0 fills first
    task automatic check_line(input logic [8:0] line);
        logic [8:0] vpos;
        logic [8:0] want;
        vpos = (line_words < `STAR_CACHE_DEPTH) ? exp_vpos0 : exp_vpos1;
        want = (vpos + fill_vdump) ^ {9{exp_flip}};
        if (check_addr) begin
            assert (line == want) else begin
                $display("ERROR %0t rom_req.addr[8:0] expected %h got %h", $time, want, line);
                addr_errs++;
            end
        end
    endtask

    // ROM model, one word per request after 0-3 pixel enables
    always @(posedge clk) begin
        #2;
        if (rst) begin
            rom_ok    = 1'b0;
            rom_armed = 1'b0;
        end else if (rom_ok) begin
            rom_ok    = 1'b0;        // word taken on the edge just passed
            rom_armed = 1'b0;
        end else if (rom_req.cs) begin
            if (!rom_armed) begin
                rnd_state = lcg_next(rnd_state);
                rom_wait  = rnd_state[25:24];
                rom_armed = 1'b1;
            end
            if (video.pxl_cen) begin // next edge is a pixel enable
                if (rom_wait == 2'd0) begin
                    rom_data = {24'd0, star_byte(rom_req.addr)};
                    rom_ok   = 1'b1;
                    check_line(rom_req.addr[8:0]);
                    line_words++;
                end else begin
                    rom_wait = rom_wait - 2'd1;
                end
            end
        end else begin
            rom_armed = 1'b0;
        end
    end

    always @(posedge clk) begin
        #1;
        if (!rst && pixel_out.pxl.color != star_pkg::CLR_TRANSP)
            star_cnt++;              // visible stars
    end

    // waits for hs to change to level
    task automatic wait_hs(input logic level);
        logic last;
        logic seen;
        int   n;
        n    = 0;
        last = video.hs;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > HS_TIMEOUT)
                abort_run("no HS edge within two lines");
            seen = (last != level) && (video.hs == level);
            last = video.hs;
        end while (!seen);
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk);
        #2;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;      // access phase
        n = 0;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            n++;
            if (n > APB_TIMEOUT)
                abort_run("pready never rose in an APB access");
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic want_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        assert (err == want_err) else begin
            $display("ERROR %0t pslverr@%h expected %b got %b", $time, addr, want_err, err);
            check_errs++;
        end
    endtask

    task automatic reg_check(input logic [7:0] addr, input logic [31:0] want, input logic want_err,
                             input string name);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        assert (rdata == want) else begin
            $display("ERROR %0t prdata@%s expected %h got %h", $time, name, want, rdata);
            check_errs++;
        end
        assert (err == want_err) else begin
            $display("ERROR %0t pslverr@%s expected %b got %b", $time, name, want_err, err);
            check_errs++;
        end
    endtask

    // one line of fill, 16 words per field
    task automatic run_line();
        logic [8:0] next_line;
        wait_hs(1'b0);
        line_words = 0;
        fill_vdump = video.vdump;
        next_line  = (fill_vdump == `STAR_VDUMP_MAX) ? 9'd0 : fill_vdump + 9'd1; // frame wrap
        wait_hs(1'b1);
        assert (video.vdump == next_line) else begin
            $display("ERROR %0t video.vdump expected %0d got %0d", $time,
                     next_line, video.vdump);
            check_errs++;
        end
        assert (line_words == 2 * `STAR_CACHE_DEPTH) else begin
            $display("ERROR %0t line_words expected %0d got %0d", $time,
                     2 * `STAR_CACHE_DEPTH, line_words);
            check_errs++;
        end
        assert (!rom_req.cs) else begin
            $display("rom_req.cs still high at the next HS, the fill burst did not end");
            check_errs++;
        end
    endtask

    task automatic begin_test();
        err_mark  = check_errs + addr_errs;
        asrt_mark = uut.u_assert.fail_cnt;
    endtask

    task automatic end_test(input string name);
        logic ok;
        ok = (check_errs + addr_errs == err_mark) && (uut.u_assert.fail_cnt == asrt_mark);
        tests_run++;
        if (!ok)
            tests_failed++;
        $display("%-14s %s", name, ok ? "passed" : "failed");
    endtask

    initial begin
        rst        = 1'b1;
        apb_req    = '0;
        rom_ok     = 1'b0;
        rom_data   = '0;
        rom_wait   = '0;
        fill_vdump = '0;
        exp_vpos0  = '0;
        exp_vpos1  = '0;
        exp_flip   = 1'b0;
        check_addr = 1'b0;
        line_words = 0;
        star_cnt   = 0;
        check_errs = 0;
        addr_errs  = 0;
        tests_run  = 0;
        tests_failed = 0;

        begin_test();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        end_test("reset");

        begin_test();
        reg_write(`STAR_REG_HPOS0, 32'h15A, 1'b0);
        reg_write(`STAR_REG_VPOS0, 32'h0A3, 1'b0);
        reg_write(`STAR_REG_HPOS1, 32'h1C7, 1'b0);
        reg_write(`STAR_REG_VPOS1, 32'h03C, 1'b0);
        reg_write(`STAR_REG_CTRL,  32'h001, 1'b0);   // flip only
        reg_write(8'h14, 32'hFFFF_FFFF, 1'b1);        // hole in the map
        reg_check(`STAR_REG_HPOS0, 32'h15A, 1'b0, "HPOS0");
        reg_check(`STAR_REG_VPOS0, 32'h0A3, 1'b0, "VPOS0");
        reg_check(`STAR_REG_HPOS1, 32'h1C7, 1'b0, "HPOS1");
        reg_check(`STAR_REG_VPOS1, 32'h03C, 1'b0, "VPOS1");
        reg_check(`STAR_REG_CTRL,  32'h001, 1'b0, "CTRL");
        reg_check(8'h14, 32'd0, 1'b1, "0x14");
        exp_vpos0 = 9'h0A3;
        exp_vpos1 = 9'h03C;
        exp_flip  = 1'b1;
        end_test("apb_regs");

        begin_test();
        repeat (3) run_line();
        end_test("fill_burst");

        begin_test();
        reg_write(`STAR_REG_CTRL, 32'h000, 1'b0);
        exp_flip = 1'b0;
        wait_hs(1'b1);               // line register settles
        check_addr = 1'b1;
        repeat (2) run_line();
        check_addr = 1'b0;
        end_test("rom_addr");

        begin_test();
        reg_write(`STAR_REG_CTRL, 32'h001, 1'b0);
        exp_flip = 1'b1;
        wait_hs(1'b1);
        check_addr = 1'b1;
        repeat (2) run_line();
        check_addr = 1'b0;
        end_test("rom_addr_flip");

        begin_test();
        reg_write(`STAR_REG_CTRL, 32'h004, 1'b0);   // en1 only
        star_cnt = 0;
        wait_hs(1'b1);
        wait_hs(1'b1);
        assert (star_cnt > 0) else begin
            $display("no star pixel came out over a line with only field 1 enabled");
            check_errs++;
        end
        end_test("mix_en1");

        begin_test();
        reg_write(`STAR_REG_CTRL, 32'h000, 1'b0);
        wait_hs(1'b1);
        wait_hs(1'b1);
        end_test("mix_off");

        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_errs + addr_errs, uut.u_assert.fail_cnt);
        if (tests_failed == 0 && check_errs + addr_errs == 0 && uut.u_assert.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/star_pkg.sv
hdl/star_video_timing.sv
hdl/star_regs.sv
hdl/star_field.sv
hdl/star_rom_arbiter.sv
hdl/star_mixer.sv
hdl/star_top.sv
sim/star_assertions.sv
sim/star_tb.sv

//--- Bender.yml
package:
  name: star_layer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/star_pkg.sv
      - hdl/star_video_timing.sv
      - hdl/star_regs.sv
      - hdl/star_field.sv
      - hdl/star_rom_arbiter.sv
      - hdl/star_mixer.sv
      - hdl/star_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/star_assertions.sv
      - sim/star_tb.sv
